/* common/frontend_params.svh */
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// Width of program counters and branch targets.
`define FE_ADDR_W 32

// Width of one instruction word.
`define FE_INST_W 32

// First fetch address after reset.
`define FE_RESET_PC 32'h1c000000

// Instruction buffer entries, a power of two.
`define FE_IB_DEPTH 16

// Branch target buffer entries, a power of two.
`define FE_BTB_ENTRIES 64

// Buffer reports full once fewer entries than this are free.
`define FE_IB_MARGIN 4

`endif

/* common/frontend_pkg.sv */
`default_nettype none

`include "frontend_params.svh"

package frontend_pkg;

    typedef logic [`FE_ADDR_W-1:0] addr_t;
    typedef logic [`FE_INST_W-1:0] inst_t;

    // BTB is indexed by word address bits above the byte offset.
    localparam int BTB_IDX_W = $clog2(`FE_BTB_ENTRIES);
    localparam int BTB_TAG_W = `FE_ADDR_W - BTB_IDX_W - 2;

    // One aligned fetch response. Slot 0 sits at pc, slot 1 at pc + 4.
    typedef struct packed {
        addr_t          pc;
        inst_t [1:0]    inst;
    } fetch_pair_t;

    // One queued instruction as handed to the back end.
    typedef struct packed {
        addr_t  pc;
        inst_t  inst;
        logic   pred_taken;
        addr_t  pred_target;
    } ib_entry_t;

    typedef struct packed {
        logic                   valid;
        logic [BTB_TAG_W-1:0]   tag;
        addr_t                  target;
        logic [1:0]             ctr;
    } btb_entry_t;

endpackage

`default_nettype wire

/* src/pc_reg.sv */
`default_nettype none

`include "frontend_params.svh"

module pc_reg
import frontend_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    icache_stall,
    input  logic    buffer_full,
    input  logic    flush,
    input  addr_t   new_pc,
    input  logic    predict_taken,
    input  addr_t   pred_target,
    output logic    fetch_req,
    output addr_t   fetch_pc,
    output logic    fetch_start_slot
);

    localparam addr_t RESET_PC   = `FE_RESET_PC;
    localparam addr_t ALIGN_MASK = ~addr_t'(7);

    logic cur_slot_q;
    logic hold_q;
    logic accept;

    // Fetch pauses for one cycle after reset and after every flush.
    assign fetch_req = ~buffer_full & ~hold_q;
    assign accept    = fetch_req & ~icache_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc         <= RESET_PC & ALIGN_MASK;
            cur_slot_q       <= RESET_PC[2];
            hold_q           <= 1'b1;
            fetch_start_slot <= 1'b0;
        end else begin
            hold_q <= flush;
            // A prediction made on the pair right after a flush comes from the
            // old path, so it is ignored while hold_q is set.
            if (flush) begin
                fetch_pc   <= new_pc & ALIGN_MASK;
                cur_slot_q <= new_pc[2];
            end else if (predict_taken && !hold_q) begin
                fetch_pc   <= pred_target & ALIGN_MASK;
                cur_slot_q <= pred_target[2];
            end else if (accept) begin
                fetch_pc   <= fetch_pc + addr_t'(8);
                cur_slot_q <= 1'b0;
            end
            // Start slot travels with the request to its response cycle.
            if (accept) begin
                fetch_start_slot <= cur_slot_q;
            end
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_pc[2:0] == 3'b000)
        else $error("fetch_pc not 8-byte aligned: %h", fetch_pc);

endmodule

`default_nettype wire

/* bpu/bpu.sv */
`default_nettype none

`include "frontend_params.svh"

module bpu
import frontend_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        resp_valid,
    input  addr_t                       resp_pc,
    input  logic [1:0][`FE_INST_W-1:0]  resp_inst,
    input  logic                        resp_start_slot,
    input  logic                        update_valid,
    input  addr_t                       update_pc,
    input  logic                        update_taken,
    input  addr_t                       update_target,
    output logic                        predict_taken,
    output addr_t                       pred_target,
    output logic [1:0]                  pred_slot_taken,
    output logic                        bpu_flush
);

    btb_entry_t btb [`FE_BTB_ENTRIES];

    logic                   wrong_path_q;
    logic                   lookup_en;
    addr_t                  slot_pc [2];
    btb_entry_t             rd_entry [2];
    logic [1:0]             slot_hit;

    logic [BTB_IDX_W-1:0]   upd_idx;
    logic [BTB_TAG_W-1:0]   upd_tag;
    btb_entry_t             upd_entry;
    logic                   upd_hit;
    logic [1:0]             next_ctr;

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    // The pair fetched right after a taken prediction is wrong path.
    assign lookup_en = resp_valid & ~wrong_path_q;

    always_comb begin
        slot_pc[0] = resp_pc;
        slot_pc[1] = resp_pc + addr_t'(4);
        for (int s = 0; s < 2; s++) begin
            rd_entry[s] = btb[slot_pc[s][2 +: BTB_IDX_W]];
            slot_hit[s] = rd_entry[s].valid && rd_entry[s].ctr[1] &&
                          (rd_entry[s].tag == slot_pc[s][`FE_ADDR_W-1 -: BTB_TAG_W]);
        end
    end

    // Slot 0 wins, and a taken slot 0 cancels slot 1.
    assign pred_slot_taken[0] = lookup_en & ~resp_start_slot & slot_hit[0];
    assign pred_slot_taken[1] = lookup_en & slot_hit[1] & ~pred_slot_taken[0];

    assign predict_taken = |pred_slot_taken;
    assign bpu_flush     = predict_taken;
    assign pred_target   = pred_slot_taken[0] ? rd_entry[0].target : rd_entry[1].target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrong_path_q <= 1'b0;
        end else begin
            wrong_path_q <= predict_taken;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Training
    ////////////////////////////////////////////////////////////////////////////

    assign upd_idx   = update_pc[2 +: BTB_IDX_W];
    assign upd_tag   = update_pc[`FE_ADDR_W-1 -: BTB_TAG_W];
    assign upd_entry = btb[upd_idx];
    assign upd_hit   = upd_entry.valid && (upd_entry.tag == upd_tag);

    always_comb begin
        if (update_taken) begin
            next_ctr = (upd_entry.ctr == 2'd3) ? 2'd3 : upd_entry.ctr + 2'd1;
        end else begin
            next_ctr = (upd_entry.ctr == 2'd0) ? 2'd0 : upd_entry.ctr - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FE_BTB_ENTRIES; i++) begin
                btb[i] <= '0;
            end
        end else if (update_valid) begin
            if (upd_hit) begin
                btb[upd_idx].ctr <= next_ctr;
                if (update_taken) begin
                    btb[upd_idx].target <= update_target;
                end
            end else if (update_taken) begin
                // New branches start weakly taken.
                btb[upd_idx] <= '{valid: 1'b1, tag: upd_tag,
                                  target: update_target, ctr: 2'd2};
            end
        end
    end

    a_one_taken_slot: assert property (@(posedge clk) disable iff (!rst_n)
        !(&pred_slot_taken))
        else $error("both slots predicted taken");

    // The icache must return defined words with every response.
    a_resp_known: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> !$isunknown(resp_inst))
        else $error("unknown instruction word in icache response");

endmodule

`default_nettype wire

/* instbuffer/instbuffer.sv */
`default_nettype none

`include "frontend_params.svh"

module instbuffer
import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        bpu_flush,
    input  logic        resp_valid,
    input  fetch_pair_t resp_pair,
    input  logic        resp_start_slot,
    input  logic [1:0]  pred_slot_taken,
    input  addr_t       pred_target,
    input  logic        send_en,
    output logic [1:0]  out_valid,
    output ib_entry_t   out_entry [2],
    output logic        buffer_full
);

    localparam int PTR_W = $clog2(`FE_IB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    ib_entry_t mem [`FE_IB_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   wr_ptr_nx;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   rd_ptr_nx;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   free_cnt;
    logic               drop_q;
    logic               wr_en;
    logic [1:0]         slot_v;
    logic [1:0]         wr_cnt;
    logic [1:0]         rd_cnt;
    ib_entry_t          slot_entry [2];
    ib_entry_t          wdata0;

    ////////////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////////////

    // A response following a flush or a taken prediction is wrong path.
    assign wr_en = resp_valid & ~drop_q & ~flush;

    // Slots run from the start slot up to the first predicted-taken slot.
    assign slot_v[0] = wr_en & ~resp_start_slot;
    assign slot_v[1] = wr_en & ~pred_slot_taken[0];
    assign wr_cnt    = {1'b0, slot_v[0]} + {1'b0, slot_v[1]};

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            slot_entry[s].pc          = resp_pair.pc + addr_t'(4 * s);
            slot_entry[s].inst        = resp_pair.inst[s];
            slot_entry[s].pred_taken  = pred_slot_taken[s];
            slot_entry[s].pred_target = pred_slot_taken[s] ? pred_target : '0;
        end
    end

    // The first written entry is slot 0 when it is valid, else slot 1.
    assign wdata0    = slot_v[0] ? slot_entry[0] : slot_entry[1];
    assign wr_ptr_nx = wr_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (wr_cnt != 2'd0) begin
            mem[wr_ptr] <= wdata0;
        end
        if (wr_cnt == 2'd2) begin
            mem[wr_ptr_nx] <= slot_entry[1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////////////////////

    assign rd_ptr_nx = rd_ptr + 1'b1;

    assign out_valid[0] = send_en & (count != '0);
    assign out_valid[1] = send_en & (count > CNT_W'(1));
    assign out_entry[0] = mem[rd_ptr];
    assign out_entry[1] = mem[rd_ptr_nx];
    assign rd_cnt       = {1'b0, out_valid[0]} + {1'b0, out_valid[1]};

    // Margin leaves room for the pair still in flight when full rises.
    assign free_cnt    = CNT_W'(`FE_IB_DEPTH) - count;
    assign buffer_full = free_cnt < CNT_W'(`FE_IB_MARGIN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop_q <= 1'b0;
        end else begin
            drop_q <= flush | bpu_flush;
            if (flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                wr_ptr <= wr_ptr + PTR_W'(wr_cnt);
                rd_ptr <= rd_ptr + PTR_W'(rd_cnt);
                count  <= count + CNT_W'(wr_cnt) - CNT_W'(rd_cnt);
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(`FE_IB_DEPTH))
        else $error("instruction buffer overflow, count %0d", count);

endmodule

`default_nettype wire

/* src/frontend_top.sv */
`default_nettype none

`include "frontend_params.svh"

module frontend_top
import frontend_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,

    // Icache side.
    input  logic                        icache_stall,
    output logic                        fetch_req,
    output addr_t                       fetch_pc,
    input  logic                        resp_valid,
    input  addr_t                       resp_pc,
    input  logic [1:0][`FE_INST_W-1:0]  resp_inst,

    // Back end side.
    input  logic                        flush,
    input  addr_t                       new_pc,
    input  logic                        update_valid,
    input  addr_t                       update_pc,
    input  logic                        update_taken,
    input  addr_t                       update_target,
    input  logic                        send_en,
    output logic [1:0]                  out_valid,
    output ib_entry_t                   out_entry [2],
    output logic                        buffer_full,
    output logic                        bpu_flush
);

    logic           predict_taken;
    addr_t          pred_target;
    logic [1:0]     pred_slot_taken;
    logic           resp_start_slot;
    fetch_pair_t    resp_pair;

    assign resp_pair.pc   = resp_pc;
    assign resp_pair.inst = resp_inst;

    pc_reg u_pc_reg (
        .clk,
        .rst_n,
        .icache_stall,
        .buffer_full,
        .flush,
        .new_pc,
        .predict_taken,
        .pred_target,
        .fetch_req,
        .fetch_pc,
        .fetch_start_slot (resp_start_slot)
    );

    bpu u_bpu (
        .clk,
        .rst_n,
        .resp_valid,
        .resp_pc,
        .resp_inst,
        .resp_start_slot,
        .update_valid,
        .update_pc,
        .update_taken,
        .update_target,
        .predict_taken,
        .pred_target,
        .pred_slot_taken,
        .bpu_flush
    );

    instbuffer u_instbuffer (
        .clk,
        .rst_n,
        .flush,
        .bpu_flush,
        .resp_valid,
        .resp_pair,
        .resp_start_slot,
        .pred_slot_taken,
        .pred_target,
        .send_en,
        .out_valid,
        .out_entry,
        .buffer_full
    );

endmodule

`default_nettype wire

/* testbench/tb_frontend.sv */
`default_nettype none

`include "frontend_params.svh"

module tb_frontend
import frontend_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t       RESET_PC  = `FE_RESET_PC;
    localparam addr_t       FLUSH_PC  = 32'h1c000804;
    localparam addr_t       BR_PC     = 32'h1c001008;
    localparam addr_t       BR_TARGET = 32'h1c002004;
    localparam addr_t       BR_LEAD   = 32'h1c000ff8;
    localparam logic [31:0] INST_KEY  = 32'h5a5a0000;

    logic                       clk;
    logic                       rst_n;
    logic                       icache_stall = 1'b0;
    logic                       fetch_req;
    addr_t                      fetch_pc;
    logic                       resp_valid = 1'b0;
    addr_t                      resp_pc = '0;
    logic [1:0][`FE_INST_W-1:0] resp_inst = '0;
    logic                       flush;
    addr_t                      new_pc;
    logic                       update_valid;
    addr_t                      update_pc;
    logic                       update_taken;
    addr_t                      update_target;
    logic                       send_en;
    logic [1:0]                 out_valid;
    ib_entry_t                  out_entry [2];
    logic                       buffer_full;
    logic                       bpu_flush;

    int         seed;
    int         errors = 0;
    int         errors_at_start;
    int         tests_run;
    int         hits_base;
    int         delivered = 0;
    int         branch_hits = 0;
    addr_t      exp_pc = RESET_PC;
    addr_t      exp_slot_pc [2];
    logic       exp_slot_taken [2];
    logic       br_live;
    logic [1:0] br_ctr;
    logic       stall_on;
    logic       idle_window;

    frontend_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of the single trained branch
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic model_taken(input addr_t pc, input logic live,
                                         input logic [1:0] ctr);
        return live && (pc == BR_PC) && ctr[1];
    endfunction

    function automatic addr_t model_next(input addr_t pc, input logic live,
                                         input logic [1:0] ctr);
        if (model_taken(pc, live, ctr)) begin
            return BR_TARGET;
        end else begin
            return pc + 32'd4;
        end
    endfunction

    always_comb begin
        exp_slot_pc[0]    = exp_pc;
        exp_slot_pc[1]    = model_next(exp_pc, br_live, br_ctr);
        exp_slot_taken[0] = model_taken(exp_slot_pc[0], br_live, br_ctr);
        exp_slot_taken[1] = model_taken(exp_slot_pc[1], br_live, br_ctr);
    end

    // Icache answers each accepted request one cycle later.
    always @(posedge clk) begin
        resp_valid   <= fetch_req && !icache_stall;
        resp_pc      <= fetch_pc;
        resp_inst[0] <= fetch_pc ^ INST_KEY;
        resp_inst[1] <= (fetch_pc + 32'd4) ^ INST_KEY;
        icache_stall <= stall_on && (($random(seed) & 3) == 0);
    end

    // The scoreboard advances the expected PC past every delivered entry.
    always @(posedge clk) begin
        if (out_valid[1]) begin
            exp_pc    <= model_next(exp_slot_pc[1], br_live, br_ctr);
            delivered <= delivered + 2;
        end else if (out_valid[0]) begin
            exp_pc    <= exp_slot_pc[1];
            delivered <= delivered + 1;
        end
        if ((out_valid[0] && exp_slot_pc[0] == BR_PC) ||
            (out_valid[1] && exp_slot_pc[1] == BR_PC)) begin
            branch_hits <= branch_hits + 1;
        end
        if (flush) begin
            exp_pc <= new_pc;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED: %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    for (genvar k = 0; k < 2; k++) begin : g_slot
        addr_t got_pc;
        inst_t got_inst;
        logic  got_taken;
        addr_t got_target;

        assign got_pc     = out_entry[k].pc;
        assign got_inst   = out_entry[k].inst;
        assign got_taken  = out_entry[k].pred_taken;
        assign got_target = out_entry[k].pred_target;

        a_pc: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[k] |-> got_pc == exp_slot_pc[k])
            else report_mismatch($sformatf("out_entry[%0d].pc", k),
                                 $sampled(got_pc), $sampled(exp_slot_pc[k]));
        a_inst: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[k] |-> got_inst == (exp_slot_pc[k] ^ INST_KEY))
            else report_mismatch($sformatf("out_entry[%0d].inst", k),
                                 $sampled(got_inst), $sampled(exp_slot_pc[k]) ^ INST_KEY);
        a_taken: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[k] |-> got_taken == exp_slot_taken[k])
            else report_mismatch($sformatf("out_entry[%0d].pred_taken", k),
                                 {31'd0, $sampled(got_taken)},
                                 {31'd0, $sampled(exp_slot_taken[k])});
        a_target: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[k] && exp_slot_taken[k] |-> got_target == BR_TARGET)
            else report_mismatch($sformatf("out_entry[%0d].pred_target", k),
                                 $sampled(got_target), BR_TARGET);
    end

    a_valid_order: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid[1] |-> out_valid[0])
        else report_mismatch("out_valid", {30'd0, $sampled(out_valid)}, 32'h3);

    a_full_stops_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        buffer_full |-> !fetch_req)
        else report_mismatch("fetch_req", {31'd0, $sampled(fetch_req)}, 32'h0);

    a_idle_flags: assert property (@(posedge clk) disable iff (!rst_n)
        idle_window |-> {out_valid, bpu_flush, buffer_full, fetch_req} == 5'd0)
        else report_mismatch("{out_valid,bpu_flush,buffer_full,fetch_req}",
                             {27'd0, $sampled({out_valid, bpu_flush, buffer_full, fetch_req})},
                             32'h0);

    a_idle_pc: assert property (@(posedge clk) disable iff (!rst_n)
        idle_window |-> fetch_pc == (RESET_PC & ~addr_t'(7)))
        else report_mismatch("fetch_pc", $sampled(fetch_pc), RESET_PC & ~addr_t'(7));

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout while %s, the wait gave up", what);
    endtask

    task automatic wait_deliveries(input int count, input int limit, input string what);
        int goal;
        int cycles;
        goal   = delivered + count;
        cycles = 0;
        while (delivered < goal && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (delivered < goal) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_full(input int limit);
        int cycles;
        cycles = 0;
        while (!buffer_full && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!buffer_full) begin
            report_timeout("waiting for buffer_full under back-pressure");
        end
    endtask

    task automatic wait_branch(input int base, input int limit);
        int cycles;
        cycles = 0;
        while (branch_hits <= base && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (branch_hits <= base) begin
            report_timeout("waiting for the branch to be delivered");
        end
    endtask

    task automatic pulse_flush(input addr_t pc);
        flush  <= 1'b1;
        new_pc <= pc;
        @(posedge clk);
        flush  <= 1'b0;
    endtask

    // Training allocates the counter at 2 and then saturates.
    task automatic train_branch(input logic taken);
        logic [1:0] ctr_nx;
        ctr_nx = br_ctr;
        if (br_live) begin
            if (taken && br_ctr != 2'd3) begin
                ctr_nx = br_ctr + 2'd1;
            end else if (!taken && br_ctr != 2'd0) begin
                ctr_nx = br_ctr - 2'd1;
            end
        end else if (taken) begin
            ctr_nx = 2'd2;
        end
        update_valid  <= 1'b1;
        update_pc     <= BR_PC;
        update_taken  <= taken;
        update_target <= BR_TARGET;
        br_live       <= br_live | taken;
        br_ctr        <= ctr_nx;
        @(posedge clk);
        update_valid  <= 1'b0;
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d checks failed", num, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed            = 56369;
        rst_n           = 1'b0;
        flush           = 1'b0;
        new_pc          = '0;
        update_valid    = 1'b0;
        update_pc       = '0;
        update_taken    = 1'b0;
        update_target   = '0;
        send_en         = 1'b0;
        br_live         = 1'b0;
        br_ctr          = 2'd0;
        stall_on        = 1'b0;
        idle_window     = 1'b0;
        tests_run       = 0;
        errors_at_start = 0;

        repeat (4) @(posedge clk);
        rst_n       <= 1'b1;
        idle_window <= 1'b1;
        send_en     <= 1'b1;
        @(posedge clk);
        idle_window <= 1'b0;
        wait_deliveries(1, 20, "waiting for the first delivery after reset");
        finish_test(1, "reset state and first fetch");

        stall_on <= 1'b1;
        wait_deliveries(120, 600, "streaming sequential fetches");
        finish_test(2, "sequential stream under icache stalls");

        send_en <= 1'b0;
        wait_full(60);
        repeat (6) @(posedge clk);
        send_en <= 1'b1;
        wait_deliveries(40, 200, "draining after back-pressure");
        finish_test(3, "back-pressure");

        // Let the buffer hold old entries so the flush has something to discard.
        send_en <= 1'b0;
        repeat (3) @(posedge clk);
        pulse_flush(FLUSH_PC);
        send_en <= 1'b1;
        wait_deliveries(20, 150, "fetching after a flush");
        finish_test(4, "flush to a slot-1 PC");

        train_branch(1'b1);
        repeat (2) @(posedge clk);
        hits_base = branch_hits;
        pulse_flush(BR_LEAD);
        wait_branch(hits_base, 100);
        wait_deliveries(8, 100, "fetching at the predicted target");
        finish_test(5, "taken prediction");

        train_branch(1'b0);
        train_branch(1'b0);
        repeat (2) @(posedge clk);
        hits_base = branch_hits;
        pulse_flush(BR_LEAD);
        wait_branch(hits_base, 100);
        wait_deliveries(8, 100, "fetching past the untaken branch");
        finish_test(6, "not-taken after training down");

        stall_on <= 1'b0;
        repeat (2) @(posedge clk);
        $display("tests run %0d, checks failed %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/frontend_pkg.sv
src/pc_reg.sv
bpu/bpu.sv
instbuffer/instbuffer.sv
src/frontend_top.sv
testbench/tb_frontend.sv

/* Makefile */
# Verilator simulation of the fetch front end.

VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
